/* hps_bridge.f */
+incdir+hw
hw/hps_cmd_pkg.sv
hw/video_pkg.sv
hw/umuldiv.sv
hw/ar_window.sv
hw/sync_conditioner.sv
hw/hps_cmd_decoder.sv
hw/hps_bridge_top.sv
test/hps_bridge_properties.sv
test/hps_bridge_tb.sv

/* hw/ar_window.sv */
// Window recomputes forever; any input change restarts the pass, settled within 64 cycles
`timescale 1ns/1ps
`include "hps_bridge_config.svh"

module ar_window
	import video_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  video_timing_t        i_timing,
	input  scale_req_t           i_scale,
	input  logic [`HB_DIM_W-1:0] i_arx,
	input  logic [`HB_DIM_W-1:0] i_ary,
	output window_t              o_window
);
	ar_state_e            state;
	video_timing_t        snap_t;
	scale_req_t           snap_s;
	logic [`HB_DIM_W-1:0] snap_arx;
	logic [`HB_DIM_W-1:0] snap_ary;
	logic [`HB_DIM_W-1:0] tgt_w;
	logic [`HB_DIM_W-1:0] tgt_h;
	logic [`HB_DIM_W-1:0] wcalc;
	logic [`HB_DIM_W-1:0] hcalc;
	logic [`HB_DIM_W-1:0] videow;
	logic [`HB_DIM_W-1:0] videoh;
	logic [`HB_DIM_W-1:0] hoff;
	logic [`HB_DIM_W-1:0] voff;
	logic [`HB_DIM_W-1:0] md_mul1;
	logic [`HB_DIM_W-1:0] md_mul2;
	logic [`HB_DIM_W-1:0] md_div;
	logic [`HB_DIM_W-1:0] md_res;
	logic                 md_start;
	logic                 md_busy;
	logic                 changed;

	assign tgt_h = (snap_s.vset != '0 && snap_s.vset < snap_t.height) ?
		snap_s.vset : snap_t.height;
	assign tgt_w = (snap_s.hset != '0 && snap_s.hset < snap_t.width) ?
		snap_s.hset : snap_t.width;
	assign changed = {i_timing, i_scale, i_arx, i_ary} != {snap_t, snap_s, snap_arx, snap_ary};
	assign hoff = (snap_t.width - videow) >> 1;
	assign voff = (snap_t.height - videoh) >> 1;

	umuldiv #(.W(`HB_DIM_W)) muldiv_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= AR_SELECT;
			md_start <= 1'b0;
		end else begin
			md_start <= 1'b0;
			if (changed && state != AR_SELECT) begin
				state <= AR_SELECT;
			end else begin
				case (state)
					AR_SELECT: begin
						snap_t   <= i_timing;
						snap_s   <= i_scale;
						snap_arx <= i_arx;
						snap_ary <= i_ary;
						state    <= AR_MUL_W;
					end
					AR_MUL_W: begin
						if (snap_s.freescale || snap_arx == '0 || snap_ary == '0) begin
							wcalc <= tgt_w;
							hcalc <= tgt_h;
							state <= AR_CLAMP;
						end else begin
							md_mul1  <= tgt_h;
							md_mul2  <= snap_arx;
							md_div   <= snap_ary;
							md_start <= 1'b1;
							state    <= AR_WAIT_W;
						end
					end
					AR_WAIT_W: begin
						if (!md_start && !md_busy) begin
							wcalc <= md_res;
							state <= AR_MUL_H;
						end
					end
					AR_MUL_H: begin
						md_mul1  <= tgt_w;
						md_mul2  <= snap_ary;
						md_div   <= snap_arx;
						md_start <= 1'b1;
						state    <= AR_WAIT_H;
					end
					AR_WAIT_H: begin
						if (!md_start && !md_busy) begin
							hcalc <= md_res;
							state <= AR_CLAMP;
						end
					end
					AR_CLAMP: begin
						videow <= (wcalc > tgt_w) ? tgt_w : wcalc;
						videoh <= (hcalc > tgt_h) ? tgt_h : hcalc;
						state  <= AR_CENTER;
					end
					AR_CENTER: begin
						o_window.hmin <= hoff;
						o_window.hmax <= hoff + videow - 1'b1;
						o_window.vmin <= voff;
						o_window.vmax <= voff + videoh - 1'b1;
						state         <= AR_SELECT;
					end
					default: state <= AR_SELECT;
				endcase
			end
		end
	end

endmodule

/* hw/hps_bridge_config.svh */
// Widths and reset values; every pixel or line dimension must stay below 4096
`ifndef HPS_BRIDGE_CONFIG_SVH
`define HPS_BRIDGE_CONFIG_SVH

// Host word port
`define HB_IO_W 16

// Pixel and line dimensions
`define HB_DIM_W 12

// Resolution out of reset
`define HB_DEF_WIDTH 12'd1920
`define HB_DEF_HEIGHT 12'd1080

// Volume attenuation, 31 is the quietest
`define HB_VOL_W 5
`define HB_DEF_VOL 5'd31

// Board LEDs
`define HB_LED_W 8

`endif

/* hw/hps_bridge_top.sv */
// Single clock domain; syncs may arrive at either polarity, aspect ratio zero means unknown
`timescale 1ns/1ps
`include "hps_bridge_config.svh"

module hps_bridge_top
	import hps_cmd_pkg::*, video_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  hps_bus_t             i_hps,
	input  logic [`HB_DIM_W-1:0] i_arx,
	input  logic [`HB_DIM_W-1:0] i_ary,
	input  logic                 i_hs_raw,
	input  logic                 i_vs_raw,
	output logic                 o_io_ack,
	output logic [`HB_IO_W-1:0]  o_io_dout,
	output logic                 o_hs,
	output logic                 o_vs,
	output logic                 o_sync,
	output logic [`HB_LED_W-1:0] o_led,
	output logic [`HB_VOL_W-1:0] o_vol_att
);
	video_timing_t timing;
	scale_req_t    scale;
	window_t       window;
	logic          csync_en;

	hps_cmd_decoder dec_i (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hps      (i_hps),
		.i_vs       (o_vs),
		.i_window   (window),
		.o_io_ack   (o_io_ack),
		.o_io_dout  (o_io_dout),
		.o_timing   (timing),
		.o_scale    (scale),
		.o_csync_en (csync_en),
		.o_led      (o_led),
		.o_vol_att  (o_vol_att)
	);

	ar_window arw_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_timing (timing),
		.i_scale  (scale),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.o_window (window)
	);

	sync_conditioner sync_i (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hs_raw   (i_hs_raw),
		.i_vs_raw   (i_vs_raw),
		.i_csync_en (csync_en),
		.o_hs       (o_hs),
		.o_vs       (o_vs),
		.o_sync     (o_sync)
	);

endmodule

/* hw/hps_cmd_decoder.sv */
// Host commands in one clock domain; io_clk must be held high until o_io_ack rises
`timescale 1ns/1ps
`include "hps_bridge_config.svh"

module hps_cmd_decoder
	import hps_cmd_pkg::*, video_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  hps_bus_t             i_hps,
	input  logic                 i_vs,
	input  window_t              i_window,
	output logic                 o_io_ack,
	output logic [`HB_IO_W-1:0]  o_io_dout,
	output video_timing_t        o_timing,
	output scale_req_t           o_scale,
	output logic                 o_csync_en,
	output logic [`HB_LED_W-1:0] o_led,
	output logic [`HB_VOL_W-1:0] o_vol_att
);
	localparam int PAD_W = `HB_IO_W - `HB_DIM_W;

	cmd_state_e           state;
	hps_opcode_e          cmd;
	hps_opcode_e          op_in;
	logic [3:0]           widx;
	logic                 echo;
	logic                 strobe;
	logic                 op_strobe;
	logic                 data_strobe;
	logic                 vs_wait;
	logic                 vs_d;
	logic                 vs_rise;
	logic [`HB_LED_W-1:0] led_mask;
	logic [`HB_LED_W-1:0] led_state;
	logic [`HB_DIM_W-1:0] rd_word;

	////////////////////////////////////////
	// Handshake

	assign strobe      = i_hps.io_clk & ~echo & ~vs_wait;
	assign op_strobe   = strobe & i_hps.uio & (state != CS_DATA);
	assign data_strobe = strobe & i_hps.uio & (state == CS_DATA);
	assign op_in       = hps_opcode_e'(i_hps.din[7:0]);
	assign vs_rise     = i_vs & ~vs_d;

	// Echo only blocks the rising io_clk while waiting for vsync
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			echo     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			if (!vs_wait || !i_hps.io_clk)
				echo <= i_hps.io_clk;
			o_io_ack <= echo;
		end
	end

	////////////////////////////////////////
	// Commands and registers

	always_comb begin
		case (widx)
			4'd0: rd_word = i_window.hmin;
			4'd1: rd_word = i_window.hmax;
			4'd2: rd_word = i_window.vmin;
			4'd3: rd_word = i_window.vmax;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state      <= CS_IDLE;
			cmd        <= OP_CFG;
			widx       <= '0;
			vs_wait    <= 1'b0;
			vs_d       <= 1'b0;
			o_io_dout  <= '0;
			o_timing   <= '{width: `HB_DEF_WIDTH, height: `HB_DEF_HEIGHT};
			o_scale    <= '0;
			o_csync_en <= 1'b0;
			led_mask   <= '0;
			led_state  <= '0;
			o_vol_att  <= `HB_DEF_VOL;
		end else begin
			vs_d <= i_vs;
			if (op_strobe && op_in == OP_WAIT_VS)
				vs_wait <= 1'b1;
			else if (vs_rise)
				vs_wait <= 1'b0;

			if (!i_hps.uio) begin
				state <= CS_IDLE;
			end else if (op_strobe) begin
				state     <= CS_DATA;
				cmd       <= op_in;
				widx      <= '0;
				o_io_dout <= '0;
			end else if (data_strobe) begin
				if (widx != '1)
					widx <= widx + 1'b1;
				o_io_dout <= '0;
				case (cmd)
					OP_CFG: o_csync_en <= i_hps.din[3];
					OP_TIMING: begin
						if (widx == 4'd0)
							o_timing.width <= i_hps.din[`HB_DIM_W-1:0];
						else if (widx == 4'd1)
							o_timing.height <= i_hps.din[`HB_DIM_W-1:0];
					end
					OP_LED: {led_mask, led_state} <= i_hps.din;
					OP_VOLUME: o_vol_att <= i_hps.din[`HB_VOL_W-1:0];
					OP_VSET: o_scale.vset <= i_hps.din[`HB_DIM_W-1:0];
					OP_HSET: begin
						o_scale.freescale <= i_hps.din[`HB_IO_W-1];
						o_scale.hset      <= i_hps.din[`HB_DIM_W-1:0];
					end
					OP_READ_WIN: o_io_dout <= {{PAD_W{1'b0}}, rd_word};
					default: ;
				endcase
			end else if (state == CS_IDLE) begin
				state <= CS_OPCODE;
			end
		end
	end

	// LEDs the host has not taken over stay dark
	assign o_led = led_mask & led_state;

endmodule

/* hw/hps_cmd_pkg.sv */
// Host command types; opcodes outside this list are accepted and ignored by the decoder
`include "hps_bridge_config.svh"

package hps_cmd_pkg;

	typedef enum logic [7:0] {
		OP_CFG      = 8'h01,
		OP_TIMING   = 8'h20,
		OP_LED      = 8'h25,
		OP_VOLUME   = 8'h26,
		OP_VSET     = 8'h27,
		OP_WAIT_VS  = 8'h30,
		OP_HSET     = 8'h37,
		OP_READ_WIN = 8'h40
	} hps_opcode_e;

	typedef enum logic [1:0] {
		CS_IDLE,
		CS_OPCODE,
		CS_DATA
	} cmd_state_e;

	// Host side of the word port
	typedef struct packed {
		logic [`HB_IO_W-1:0] din;
		logic                io_clk;
		logic                uio;
	} hps_bus_t;

endpackage

/* hw/sync_conditioner.sv */
// Raw syncs must be stable for a few frames before the polarity decision holds
`timescale 1ns/1ps

module sync_conditioner (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs_raw,
	input  logic i_vs_raw,
	input  logic i_csync_en,
	output logic o_hs,
	output logic o_vs,
	output logic o_sync
);
	localparam int CNT_W = 24;

	logic [1:0]       raw;
	logic [1:0]       cond;
	logic             hs_d;
	logic             stretch;
	logic             cs_comb;
	logic [CNT_W-1:0] h_cnt;
	logic [CNT_W-1:0] line_len;
	logic [CNT_W-1:0] hs_len;

	assign raw = {i_vs_raw, i_hs_raw};

	////////////////////////////////////////
	// Polarity, bit 0 hsync and bit 1 vsync

	for (genvar g = 0; g < 2; g++) begin : g_pol
		logic             prev;
		logic             pol;
		logic [CNT_W-1:0] cnt;
		logic [CNT_W-1:0] hi_len;
		logic [CNT_W-1:0] lo_len;

		always_ff @(posedge clk_sys) begin
			if (resetd) begin
				prev   <= 1'b0;
				pol    <= 1'b0;
				cnt    <= '0;
				hi_len <= '0;
				lo_len <= '0;
			end else begin
				prev <= raw[g];
				if (prev != raw[g]) begin
					cnt <= '0;
					// Longer phase is the inactive one
					if (raw[g]) begin
						lo_len <= cnt;
						pol    <= hi_len > cnt;
					end else begin
						hi_len <= cnt;
						pol    <= cnt > lo_len;
					end
				end else if (cnt != '1) begin
					cnt <= cnt + 1'b1;
				end
			end
		end

		assign cond[g] = raw[g] ^ pol;
	end

	assign o_hs = cond[0];
	assign o_vs = cond[1];

	////////////////////////////////////////
	// Compound sync

	// Broad pulses in vsync, from hsync rise to one hsync width before the next line
	assign cs_comb = o_vs ? (o_hs | stretch) : o_hs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_d     <= 1'b0;
			stretch  <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			o_sync   <= 1'b0;
		end else begin
			hs_d <= o_hs;
			if (h_cnt != '1)
				h_cnt <= h_cnt + 1'b1;
			if (o_hs && !hs_d) begin
				h_cnt    <= '0;
				line_len <= h_cnt;
				stretch  <= 1'b1;
			end else begin
				if (!o_hs && hs_d)
					hs_len <= h_cnt;
				if (h_cnt == line_len - hs_len)
					stretch <= 1'b0;
			end
			o_sync <= i_csync_en ? cs_comb : o_hs;
		end
	end

endmodule

/* hw/umuldiv.sv */
// Returns mul1*mul2/div; a quotient wider than W bits or a zero divisor gives all ones
`timescale 1ns/1ps
`include "hps_bridge_config.svh"

module umuldiv #(
	parameter int W = `HB_DIM_W
) (
	input  logic         clk_sys,
	input  logic         resetd,
	input  logic         i_start,
	input  logic [W-1:0] i_mul1,
	input  logic [W-1:0] i_mul2,
	input  logic [W-1:0] i_div,
	output logic         o_busy,
	output logic [W-1:0] o_result
);
	localparam int CW = $clog2(W + 2);

	logic [CW-1:0]  step;
	logic [W-1:0]   mul1;
	logic [W-1:0]   mul2;
	logic [W-1:0]   divisor;
	logic [W-1:0]   quo;
	logic [W:0]     rem;
	logic [W:0]     shifted;
	logic [2*W-1:0] prod;
	logic           ovf;

	assign prod    = mul1 * mul2;
	assign shifted = {rem[W-1:0], quo[W-1]};

	// Load, W division steps, result
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			step   <= '0;
		end else if (o_busy) begin
			step <= step + 1'b1;
			if (step == CW'(W + 1))
				o_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			mul1    <= i_mul1;
			mul2    <= i_mul2;
			divisor <= i_div;
		end else if (o_busy) begin
			if (step == '0) begin
				rem <= {1'b0, prod[2*W-1:W]};
				quo <= prod[W-1:0];
				// Also true for a zero divisor
				ovf <= prod[2*W-1:W] >= divisor;
			end else if (step == CW'(W + 1)) begin
				o_result <= ovf ? '1 : quo;
			end else if (shifted >= {1'b0, divisor}) begin
				rem <= shifted - {1'b0, divisor};
				quo <= {quo[W-2:0], 1'b1};
			end else begin
				rem <= shifted;
				quo <= {quo[W-2:0], 1'b0};
			end
		end
	end

endmodule

/* hw/video_pkg.sv */
// Video geometry types; all sizes are in pixels or lines, HB_DIM_W bits each
`include "hps_bridge_config.svh"

package video_pkg;

	typedef struct packed {
		logic [`HB_DIM_W-1:0] width;
		logic [`HB_DIM_W-1:0] height;
	} video_timing_t;

	// Zero vset or hset means no override
	typedef struct packed {
		logic [`HB_DIM_W-1:0] vset;
		logic [`HB_DIM_W-1:0] hset;
		logic                 freescale;
	} scale_req_t;

	typedef struct packed {
		logic [`HB_DIM_W-1:0] hmin;
		logic [`HB_DIM_W-1:0] hmax;
		logic [`HB_DIM_W-1:0] vmin;
		logic [`HB_DIM_W-1:0] vmax;
	} window_t;

	typedef enum logic [2:0] {
		AR_SELECT, AR_MUL_W, AR_WAIT_W, AR_MUL_H, AR_WAIT_H, AR_CLAMP, AR_CENTER
	} ar_state_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the hps_bridge testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f hps_bridge.f --top-module hps_bridge_tb \
	-o hps_bridge_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/hps_bridge_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" sim.log; then
	echo "simulation PASS"
	exit 0
fi
echo "simulation FAIL"
exit 1

/* test/hps_bridge_properties.sv */
// Bound to hps_bridge_top; tracks the LED mask from host words and needs uio low between commands
`timescale 1ns/1ps
`include "hps_bridge_config.svh"

module hps_bridge_properties
	import hps_cmd_pkg::*;
(
	input logic                 clk_sys,
	input logic                 resetd,
	input logic                 io_clk,
	input logic                 uio,
	input logic [`HB_IO_W-1:0]  din,
	input logic                 io_ack,
	input logic [`HB_LED_W-1:0] led
);
	logic                 clk_d;
	logic                 op_next;
	logic [7:0]           op;
	logic [`HB_LED_W-1:0] mask;

	// Overtake mask as the host last wrote it
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_d   <= 1'b0;
			op_next <= 1'b1;
			op      <= '0;
			mask    <= '0;
		end else begin
			clk_d <= io_clk;
			if (!uio) begin
				op_next <= 1'b1;
			end else if (io_clk && !clk_d) begin
				op_next <= 1'b0;
				if (op_next)
					op <= din[7:0];
				else if (op == OP_LED)
					mask <= din[`HB_IO_W-1:`HB_LED_W];
			end
		end
	end

	a_ack_in_reset: assert property (@(posedge clk_sys)
		resetd && $past(resetd) |-> !io_ack)
		else $error("acknowledge high during reset");

	// Host holds io_clk until it sees the acknowledge
	a_ack_needs_clk: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(io_ack) |-> io_clk)
		else $error("acknowledge rose without io_clk");

	a_led_masked: assert property (@(posedge clk_sys) disable iff (resetd)
		(led & ~mask) == '0)
		else $error("LED lit outside the overtake mask");

endmodule

bind hps_bridge_top hps_bridge_properties props_i (
	.clk_sys (clk_sys),
	.resetd  (resetd),
	.io_clk  (i_hps.io_clk),
	.uio     (i_hps.uio),
	.din     (i_hps.din),
	.io_ack  (o_io_ack),
	.led     (o_led)
);

/* test/hps_bridge_tb.sv */
// Single clock testbench; sync generator runs free, every wait is bounded by a cycle count
`timescale 1ns/1ps

module hps_bridge_tb
	import hps_cmd_pkg::*, video_pkg::*;
();
	typedef struct packed {
		logic [11:0] width;
		logic [11:0] height;
		logic [11:0] vset;
		logic [11:0] hset;
		logic        fs;
		logic [11:0] arx;
		logic [11:0] ary;
	} win_row_t;

	localparam int NROWS     = 7;
	localparam int HS_TMO    = 200;
	localparam int FRAME_TMO = 8000;

	logic        clk_sys;
	logic        resetd;
	hps_bus_t    hps;
	logic [11:0] arx;
	logic [11:0] ary;
	logic        hs_raw = 1'b0;
	logic        vs_raw = 1'b0;
	logic        o_io_ack;
	logic [15:0] o_io_dout;
	logic        o_hs;
	logic        o_vs;
	logic        o_sync;
	logic [7:0]  o_led;
	logic [4:0]  o_vol_att;

	logic [31:0] rng;
	logic        sync_neg;
	int          h_pos;
	int          v_line;
	int          line_len;
	int          frame_lines;
	int          frame_cnt;
	int          err_cnt;
	int          test_cnt;
	int          fail_tests;
	int          errs_at_start;
	string       cur_test;
	logic [15:0] rd_win [4];
	win_row_t    rows [NROWS];
	string       row_name [NROWS];

	hps_bridge_top dut_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_hps     (hps),
		.i_arx     (arx),
		.i_ary     (ary),
		.i_hs_raw  (hs_raw),
		.i_vs_raw  (vs_raw),
		.o_io_ack  (o_io_ack),
		.o_io_dout (o_io_dout),
		.o_hs      (o_hs),
		.o_vs      (o_vs),
		.o_sync    (o_sync),
		.o_led     (o_led),
		.o_vol_att (o_vol_att)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Window by the aspect rule, in plain integer arithmetic
	function automatic window_t expect_window(input win_row_t r);
		window_t w;
		int      tw;
		int      th;
		int      vw;
		int      vh;
		tw = (r.hset != 0 && r.hset < r.width) ? int'(r.hset) : int'(r.width);
		th = (r.vset != 0 && r.vset < r.height) ? int'(r.vset) : int'(r.height);
		if (r.fs || r.arx == 0 || r.ary == 0) begin
			vw = tw;
			vh = th;
		end else begin
			vw = th * int'(r.arx) / int'(r.ary);
			vh = tw * int'(r.ary) / int'(r.arx);
		end
		if (vw > tw)
			vw = tw;
		if (vh > th)
			vh = th;
		w.hmin = 12'((int'(r.width) - vw) / 2);
		w.hmax = 12'((int'(r.width) - vw) / 2 + vw - 1);
		w.vmin = 12'((int'(r.height) - vh) / 2);
		w.vmax = 12'((int'(r.height) - vh) / 2 + vh - 1);
		return w;
	endfunction

	////////////////////////////////////////
	// Sync generator, new line and frame lengths each frame

	always @(posedge clk_sys) begin
		if (resetd) begin
			h_pos       <= 0;
			v_line      <= 0;
			rng         <= 32'd68;
			line_len    <= 48;
			frame_lines <= 24;
			frame_cnt   <= 0;
			hs_raw      <= sync_neg;
			vs_raw      <= sync_neg;
		end else begin
			if (h_pos == line_len - 1) begin
				h_pos <= 0;
				if (v_line == frame_lines - 1) begin
					v_line      <= 0;
					rng         <= xorshift32(rng);
					line_len    <= 40 + int'(rng[4:0]);
					frame_lines <= 20 + int'(rng[12:8]);
					frame_cnt   <= frame_cnt + 1;
				end else begin
					v_line <= v_line + 1;
				end
			end else begin
				h_pos <= h_pos + 1;
			end
			hs_raw <= (h_pos < 6) ^ sync_neg;
			vs_raw <= (v_line < 3) ^ sync_neg;
		end
	end

	////////////////////////////////////////
	// Host side

	task automatic start_test(input string name);
		cur_test      = name;
		errs_at_start = err_cnt;
	endtask

	task automatic end_test();
		test_cnt++;
		if (err_cnt == errs_at_start) begin
			$display("PASS %s", cur_test);
		end else begin
			fail_tests++;
			$display("FAIL %s", cur_test);
		end
	endtask

	task automatic send_word(input logic [15:0] w, output int lat, output logic [15:0] dout);
		int n;
		@(posedge clk_sys);
		hps.din    <= w;
		hps.uio    <= 1'b1;
		hps.io_clk <= 1'b1;
		// Clock edges after the one that raised io_clk
		lat = 0;
		@(negedge clk_sys);
		while (!o_io_ack && lat < HS_TMO) begin
			@(negedge clk_sys);
			lat++;
		end
		dout = o_io_dout;
		if (!o_io_ack) begin
			$display("%s: no acknowledge for word %h", cur_test, w);
			err_cnt++;
		end
		@(posedge clk_sys);
		hps.io_clk <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (o_io_ack && n < HS_TMO);
		if (o_io_ack) begin
			$display("%s: acknowledge stuck high", cur_test);
			err_cnt++;
		end
	endtask

	task automatic end_cmd();
		@(posedge clk_sys);
		hps.uio <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic host_cmd(input logic [7:0] op, input int n, input logic [15:0] d0,
		input logic [15:0] d1);
		int          lat;
		logic [15:0] dout;
		send_word({8'h00, op}, lat, dout);
		if (n > 0)
			send_word(d0, lat, dout);
		if (n > 1)
			send_word(d1, lat, dout);
		end_cmd();
	endtask

	task automatic host_read();
		int          lat;
		logic [15:0] dout;
		send_word({8'h00, OP_READ_WIN}, lat, dout);
		for (int i = 0; i < 4; i++)
			send_word(16'h0000, lat, rd_win[i]);
		end_cmd();
	endtask

	task automatic wait_frames(input int n);
		int start;
		int cyc;
		start = frame_cnt;
		cyc   = 0;
		while (frame_cnt - start < n && cyc < n * FRAME_TMO) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (frame_cnt - start < n) begin
			$display("%s: sync generator stopped producing frames", cur_test);
			err_cnt++;
		end
	endtask

	// One frame of polarity and compound sync checks, first mismatch only
	task automatic check_frame(input bit csync_on);
		int   start;
		int   cyc;
		bit   bad;
		bit   broad_seen;
		logic prev_hs;
		logic prev_vs;
		@(negedge clk_sys);
		start      = frame_cnt;
		cyc        = 0;
		bad        = 1'b0;
		broad_seen = 1'b0;
		prev_hs    = o_hs;
		prev_vs    = o_vs;
		while (frame_cnt == start && cyc < FRAME_TMO) begin
			@(negedge clk_sys);
			cyc++;
			if (!bad && o_hs !== (hs_raw ^ sync_neg)) begin
				$display("ERR %s o_hs expected %b actual %b", cur_test, hs_raw ^ sync_neg, o_hs);
				bad = 1'b1;
			end
			if (!bad && o_vs !== (vs_raw ^ sync_neg)) begin
				$display("ERR %s o_vs expected %b actual %b", cur_test, vs_raw ^ sync_neg, o_vs);
				bad = 1'b1;
			end
			if (!bad && (!csync_on || !prev_vs) && o_sync !== prev_hs) begin
				$display("ERR %s o_sync expected %b actual %b", cur_test, prev_hs, o_sync);
				bad = 1'b1;
			end
			// Compound sync stays high past the end of hsync in vsync
			if (csync_on && prev_vs && !prev_hs && o_sync)
				broad_seen = 1'b1;
			prev_hs = o_hs;
			prev_vs = o_vs;
		end
		if (bad)
			err_cnt++;
		if (csync_on && !broad_seen) begin
			$display("%s: no broad pulse on o_sync during vsync", cur_test);
			err_cnt++;
		end
		if (frame_cnt == start) begin
			$display("%s: frame did not end", cur_test);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////
	// Sequence

	initial begin
		int          lat;
		int          cyc;
		bit          vs_seen;
		logic [15:0] dout;
		window_t     exp;
		hps         = '0;
		arx         = 12'd16;
		ary         = 12'd9;
		sync_neg    = 1'b0;
		resetd      = 1'b1;
		err_cnt     = 0;
		test_cnt    = 0;
		fail_tests  = 0;
		row_name[0] = "win_no_override";
		rows[0]     = '{12'd1920, 12'd1080, 12'd0, 12'd0, 1'b0, 12'd16, 12'd9};
		row_name[1] = "win_vset";
		rows[1]     = '{12'd1920, 12'd1080, 12'd720, 12'd0, 1'b0, 12'd16, 12'd9};
		row_name[2] = "win_hset";
		rows[2]     = '{12'd1280, 12'd720, 12'd0, 12'd1000, 1'b0, 12'd4, 12'd3};
		row_name[3] = "win_zero_aspect";
		rows[3]     = '{12'd1024, 12'd768, 12'd0, 12'd0, 1'b0, 12'd0, 12'd3};
		row_name[4] = "win_wide";
		rows[4]     = '{12'd800, 12'd600, 12'd0, 12'd0, 1'b0, 12'd21, 12'd9};
		row_name[5] = "win_tall";
		rows[5]     = '{12'd1920, 12'd1080, 12'd0, 12'd0, 1'b0, 12'd3, 12'd4};
		row_name[6] = "win_freescale";
		rows[6]     = '{12'd1920, 12'd1080, 12'd600, 12'd800, 1'b1, 12'd4, 12'd3};

		repeat (16) @(posedge clk_sys);
		resetd <= 1'b0;
		@(posedge clk_sys);

		start_test("reset");
		@(negedge clk_sys);
		if (o_io_ack !== 1'b0)
			$display("ERR %s o_io_ack expected 0 actual %b", cur_test, o_io_ack);
		if (o_led !== 8'h00)
			$display("ERR %s o_led expected 00 actual %h", cur_test, o_led);
		if (o_vol_att !== 5'd31)
			$display("ERR %s o_vol_att expected 31 actual %0d", cur_test, o_vol_att);
		if (o_io_ack !== 1'b0 || o_led !== 8'h00 || o_vol_att !== 5'd31)
			err_cnt++;
		send_word({8'h00, OP_CFG}, lat, dout);
		if (lat != 2) begin
			$display("ERR %s ack latency expected 2 actual %0d", cur_test, lat);
			err_cnt++;
		end
		send_word(16'h0000, lat, dout);
		end_cmd();
		end_test();

		start_test("led_volume");
		host_cmd(OP_LED, 1, 16'hF0AA, 16'h0000);
		@(negedge clk_sys);
		if (o_led !== 8'hA0) begin
			$display("ERR %s o_led expected a0 actual %h", cur_test, o_led);
			err_cnt++;
		end
		host_cmd(OP_VOLUME, 1, 16'h0007, 16'h0000);
		@(negedge clk_sys);
		if (o_vol_att !== 5'd7) begin
			$display("ERR %s o_vol_att expected 7 actual %0d", cur_test, o_vol_att);
			err_cnt++;
		end
		end_test();

		for (int i = 0; i < NROWS; i++) begin
			start_test(row_name[i]);
			@(posedge clk_sys);
			arx <= rows[i].arx;
			ary <= rows[i].ary;
			host_cmd(OP_TIMING, 2, {4'h0, rows[i].width}, {4'h0, rows[i].height});
			host_cmd(OP_VSET, 1, {4'h0, rows[i].vset}, 16'h0000);
			host_cmd(OP_HSET, 1, {rows[i].fs, 3'b000, rows[i].hset}, 16'h0000);
			repeat (64) @(posedge clk_sys);
			host_read();
			exp = expect_window(rows[i]);
			if (rd_win[0] !== {4'h0, exp.hmin}) begin
				$display("ERR %s hmin expected %0d actual %0d", cur_test, exp.hmin, rd_win[0]);
				err_cnt++;
			end
			if (rd_win[1] !== {4'h0, exp.hmax}) begin
				$display("ERR %s hmax expected %0d actual %0d", cur_test, exp.hmax, rd_win[1]);
				err_cnt++;
			end
			if (rd_win[2] !== {4'h0, exp.vmin}) begin
				$display("ERR %s vmin expected %0d actual %0d", cur_test, exp.vmin, rd_win[2]);
				err_cnt++;
			end
			if (rd_win[3] !== {4'h0, exp.vmax}) begin
				$display("ERR %s vmax expected %0d actual %0d", cur_test, exp.vmax, rd_win[3]);
				err_cnt++;
			end
			end_test();
		end

		start_test("sync_active_high");
		wait_frames(2);
		check_frame(1'b0);
		end_test();

		start_test("sync_active_low");
		@(posedge clk_sys);
		sync_neg <= 1'b1;
		wait_frames(3);
		check_frame(1'b0);
		end_test();

		start_test("compound_sync");
		host_cmd(OP_CFG, 1, 16'h0008, 16'h0000);
		// Start at a frame boundary so the checked frame holds a whole vsync
		wait_frames(1);
		check_frame(1'b1);
		end_test();

		// Start right after vsync ends so the blocked word sees a long low phase
		start_test("wait_vsync");
		cyc = 0;
		while (!o_vs && cyc < FRAME_TMO) begin
			@(negedge clk_sys);
			cyc++;
		end
		while (o_vs && cyc < FRAME_TMO) begin
			@(negedge clk_sys);
			cyc++;
		end
		send_word({8'h00, OP_WAIT_VS}, lat, dout);
		@(posedge clk_sys);
		hps.din    <= 16'h1234;
		hps.io_clk <= 1'b1;
		vs_seen = 1'b0;
		cyc     = 0;
		do begin
			@(negedge clk_sys);
			cyc++;
			if (o_vs)
				vs_seen = 1'b1;
		end while (!o_io_ack && cyc < FRAME_TMO);
		if (o_io_ack && !vs_seen) begin
			$display("%s: word acknowledged before vsync rose", cur_test);
			err_cnt++;
		end
		if (!o_io_ack) begin
			$display("%s: no acknowledge after vsync", cur_test);
			err_cnt++;
		end
		@(posedge clk_sys);
		hps.io_clk <= 1'b0;
		cyc = 0;
		do begin
			@(negedge clk_sys);
			cyc++;
		end while (o_io_ack && cyc < HS_TMO);
		if (o_io_ack) begin
			$display("%s: acknowledge stuck high", cur_test);
			err_cnt++;
		end
		end_cmd();
		end_test();

		$display("%0d tests run, %0d passed, %0d failed", test_cnt, test_cnt - fail_tests,
			fail_tests);
		if (fail_tests == 0 && err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
